/* all.f */
+incdir+source
source/video_pkg.sv
source/regs_pkg.sv
source/lcd_timing.sv
source/video_ram.sv
source/lcd_regs.sv
source/window_compositor.sv
source/lcd_top.sv
sim/lcd_checker.sv
sim/lcd_top_tb.sv

/* sim/lcd_top_tb.sv */
`default_nettype none
`timescale 1ns/10ps
`include "lcd_cfg.svh"

module lcd_top_tb;

	localparam int OP_RD = 0;
	localparam int OP_WR = 1;
	localparam int OP_LOAD = 2;
	localparam int OP_FRAMES = 3;
	localparam int BUS_LIMIT = 50;
	localparam int FRAME_LIMIT = 2 * (`H_ACTIVE + `H_FP + `H_SYNC + `H_BP) *
		(`V_ACTIVE + `V_FP + `V_SYNC + `V_BP);
	localparam logic [1:0] OK = 2'b00;
	localparam logic [1:0] ERR = 2'b10;

	logic pixel_clk;
	logic rst;
	logic [7:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [7:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic lcd_clk;
	logic lcd_hsync;
	logic lcd_vsync;
	logic lcd_den;
	logic [`R_MSB:0] lcd_r;
	logic [`G_MSB:0] lcd_g;
	logic [`B_MSB:0] lcd_b;

	// stimulus table: operation, offset, data, response, read data, frames to wait, stall
	int step_op [0:39];
	logic [7:0] step_off [0:39];
	logic [31:0] step_data [0:39];
	logic [1:0] step_resp [0:39];
	int step_frames [0:39];
	int step_hold [0:39];
	int steps;
	int seed;
	int timeouts;
	logic timed_out;

	lcd_top uut (
		.pixel_clk(pixel_clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.lcd_clk(lcd_clk), .lcd_hsync(lcd_hsync), .lcd_vsync(lcd_vsync),
		.lcd_den(lcd_den), .lcd_r(lcd_r), .lcd_g(lcd_g), .lcd_b(lcd_b)
	);

	lcd_checker chk (
		.pixel_clk(pixel_clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.lcd_clk(lcd_clk), .lcd_hsync(lcd_hsync), .lcd_vsync(lcd_vsync), .lcd_den(lcd_den),
		.lcd_r(lcd_r), .lcd_g(lcd_g), .lcd_b(lcd_b)
	);

	initial begin
		pixel_clk = 1'b0;
		forever #2 pixel_clk = ~pixel_clk;
	end

	task automatic add_step(input int op, input logic [7:0] off, input logic [31:0] data,
		input logic [1:0] resp, input int frames, input int hold);
		step_op[steps] = op;
		step_off[steps] = off;
		step_data[steps] = data;
		step_resp[steps] = resp;
		step_frames[steps] = frames;
		step_hold[steps] = hold;
		steps++;
	endtask

	function automatic logic flag_of(input int which);
		case (which)
			0: return awready;
			1: return bvalid;
			2: return arready;
			3: return rvalid;
			4: return lcd_vsync;
			default: return !lcd_vsync;
		endcase
	endfunction

	task automatic wait_for(input int which, input string name, input int limit);
		int n;
		n = 0;
		if (!timed_out) begin
			do begin
				@(negedge pixel_clk);
				n++;
				if (n > limit) begin
					$display("Timeout at %0t while waiting for %s", $time, name);
					timeouts++;
					timed_out = 1'b1;
				end
			end while (!timed_out && !flag_of(which));
		end
	endtask

	task automatic wait_vsync_falls(input int count);
		repeat (count) begin
			wait_for(4, "vsync high", FRAME_LIMIT);
			wait_for(5, "vsync falling", FRAME_LIMIT);
		end
		@(posedge pixel_clk);
		#1;
	endtask

	task automatic axi_write(input logic [7:0] off, input logic [31:0] data,
		input logic [1:0] resp, input int hold);
		chk.expect_response(resp, 32'd0, 1'b0);
		awaddr = off;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = (hold == 0);
		wait_for(0, "awready", BUS_LIMIT);
		@(posedge pixel_clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		if (hold > 0) begin
			repeat (hold) @(posedge pixel_clk);
			#1;
			bready = 1'b1;
		end
		wait_for(1, "bvalid", BUS_LIMIT);
		@(posedge pixel_clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] off, input logic [1:0] resp,
		input logic [31:0] data, input logic check_data, input int hold);
		chk.expect_response(resp, data, check_data);
		araddr = off;
		arvalid = 1'b1;
		rready = (hold == 0);
		wait_for(2, "arready", BUS_LIMIT);
		@(posedge pixel_clk);
		#1;
		arvalid = 1'b0;
		if (hold > 0) begin
			repeat (hold) @(posedge pixel_clk);
			#1;
			rready = 1'b1;
		end
		wait_for(3, "rvalid", BUS_LIMIT);
		@(posedge pixel_clk);
		#1;
		rready = 1'b0;
	endtask

	task automatic apply_step(input int i);
		case (step_op[i])
			OP_RD: axi_read(step_off[i], step_resp[i], step_data[i], step_resp[i] == OK,
				step_hold[i]);
			OP_WR: axi_write(step_off[i], step_data[i], step_resp[i], step_hold[i]);
			OP_LOAD: begin
				for (int k = 0; k < 2048 && !timed_out; k++) begin
					axi_write(8'h14, $random(seed) & 32'hff, OK, 0);
				end
			end
			default: begin
				// read right after vsync falls, well clear of the frame end
				wait_vsync_falls(1);
				axi_read(8'h18, OK, 32'd0, 1'b0, 0);
				wait_vsync_falls(step_data[i]);
				chk.expect_frame_growth(step_data[i]);
				axi_read(8'h18, OK, 32'd0, 1'b0, 0);
			end
		endcase
		if (step_frames[i] > 0) begin
			wait_vsync_falls(step_frames[i]);
		end
	endtask

	initial begin
		int errors;
		seed = 32'h5f37_bfb4;
		timeouts = 0;
		timed_out = 1'b0;
		steps = 0;
		rst = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'hf;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;

		add_step(OP_RD, 8'h00, 32'h1, OK, 0, 0);
		add_step(OP_RD, 8'h04, 32'h0, OK, 0, 0);
		add_step(OP_RD, 8'h08, 32'h0, OK, 0, 0);
		add_step(OP_RD, 8'h0C, 32'h0, OK, 0, 0);
		add_step(OP_RD, 8'h10, 32'h0, OK, 0, 0);
		add_step(OP_RD, 8'h18, 32'h0, OK, 0, 0);
		add_step(OP_WR, 8'h04, 32'd100, OK, 0, 3);
		add_step(OP_RD, 8'h04, 32'd100, OK, 0, 3);
		add_step(OP_WR, 8'h08, 32'd80, OK, 0, 0);
		add_step(OP_RD, 8'h08, 32'd80, OK, 0, 0);
		add_step(OP_WR, 8'h0C, 32'hf81f, OK, 0, 0);
		add_step(OP_RD, 8'h0C, 32'hf81f, OK, 0, 0);
		add_step(OP_WR, 8'h10, 32'h7fe, OK, 0, 0);
		add_step(OP_RD, 8'h10, 32'h7fe, OK, 0, 0);
		add_step(OP_WR, 8'h10, 32'h0, OK, 0, 0);
		add_step(OP_WR, 8'h18, 32'h5, ERR, 0, 0);
		add_step(OP_WR, 8'h1C, 32'h1, ERR, 0, 2);
		add_step(OP_RD, 8'h1C, 32'h0, ERR, 0, 0);
		add_step(OP_RD, 8'h40, 32'h0, ERR, 0, 0);
		add_step(OP_LOAD, 8'h14, 32'h0, OK, 0, 0);
		add_step(OP_RD, 8'h10, 32'h0, OK, 0, 0);
		add_step(OP_RD, 8'h14, 32'h0, OK, 0, 0);
		add_step(OP_WR, 8'h00, 32'h1, OK, 2, 0);
		add_step(OP_WR, 8'h00, 32'h3, OK, 2, 0);
		add_step(OP_WR, 8'h04, 32'd300, OK, 0, 0);
		add_step(OP_WR, 8'h08, 32'd200, OK, 2, 0);
		add_step(OP_WR, 8'h00, 32'h2, OK, 2, 0);
		add_step(OP_WR, 8'h00, 32'h3, OK, 0, 0);
		add_step(OP_FRAMES, 8'h18, 32'd3, OK, 0, 0);

		repeat (10) @(posedge pixel_clk);
		#1;
		rst = 1'b1;

		for (int i = 0; i < steps && !timed_out; i++) begin
			apply_step(i);
		end
		repeat (5) @(posedge pixel_clk);

		errors = chk.value_errors + chk.other_errors + timeouts;
		$display("value errors %0d, other errors %0d, timeouts %0d",
			chk.value_errors, chk.other_errors, timeouts);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim/lcd_checker.sv */
`default_nettype none
`timescale 1ns/10ps
`include "lcd_cfg.svh"

module lcd_checker (
	input wire logic pixel_clk,
	input wire logic rst,
	input wire logic [7:0] awaddr,
	input wire logic awvalid,
	input wire logic awready,
	input wire logic [31:0] wdata,
	input wire logic wvalid,
	input wire logic wready,
	input wire logic [1:0] bresp,
	input wire logic bvalid,
	input wire logic bready,
	input wire logic [7:0] araddr,
	input wire logic arvalid,
	input wire logic arready,
	input wire logic [31:0] rdata,
	input wire logic [1:0] rresp,
	input wire logic rvalid,
	input wire logic rready,
	input wire logic lcd_clk,
	input wire logic lcd_hsync,
	input wire logic lcd_vsync,
	input wire logic lcd_den,
	input wire logic [`R_MSB:0] lcd_r,
	input wire logic [`G_MSB:0] lcd_g,
	input wire logic [`B_MSB:0] lcd_b
);

	localparam int PRINT_LIMIT = 30;
	localparam logic [1:0] OKAY = 2'b00;
	localparam logic [1:0] SLVERR = 2'b10;

	int value_errors;
	int other_errors;
	logic [1:0] ctrl;
	logic [9:0] win_x;
	logic [9:0] win_y;
	logic [15:0] bg_color;
	logic [10:0] vram_addr;
	logic [7:0] ram [0:2047];
	bit ram_known [0:2047];
	logic [34:0] expected [$];
	logic [1:0] wr_model_resp;
	logic [33:0] rd_model;
	logic rd_frame;
	logic bvalid_stall;
	logic rvalid_stall;
	logic vsync_prev;
	logic dirty;
	logic synced;
	int pix_cnt;
	int vsync_rises;
	int rises_at_read;
	logic [31:0] frame_at_read;
	int frame_growth;

	initial begin
		value_errors = 0;
		other_errors = 0;
	end

	// the testbench queues what it expects for each transaction, in bus order
	task automatic expect_response(input logic [1:0] resp, input logic [31:0] data,
		input logic check_data);
		expected.push_back({check_data, resp, data});
	endtask

	// the next FRAME_CNT read must show this many more frames than the one before it
	task automatic expect_frame_growth(input int frames);
		frame_growth = frames;
	endtask

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			value_errors++;
			if (value_errors <= PRINT_LIMIT) begin
				$display("Fail %0t %s expected %h actual %h", $time, name, exp, act);
			end
		end
	endtask

	task automatic report_other(input string what);
		other_errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	function automatic logic [1:0] write_resp(input logic [7:0] off);
		if (off == 8'h00 || off == 8'h04 || off == 8'h08 || off == 8'h0C || off == 8'h10 ||
			off == 8'h14) begin
			return OKAY;
		end
		return SLVERR;
	endfunction

	// response code in the top two bits, read data below
	function automatic logic [33:0] read_model(input logic [7:0] off);
		case (off)
			8'h00: return {OKAY, 30'd0, ctrl};
			8'h04: return {OKAY, 22'd0, win_x};
			8'h08: return {OKAY, 22'd0, win_y};
			8'h0C: return {OKAY, 16'd0, bg_color};
			8'h10: return {OKAY, 21'd0, vram_addr};
			8'h14: return {OKAY, 32'd0};
			8'h18: return {OKAY, 32'd0};
			default: return {SLVERR, 32'd0};
		endcase
	endfunction

	task automatic bus_step();
		logic [34:0] e;
		if (bvalid_stall && !bvalid) begin
			report_other("bvalid dropped while bready was low");
		end
		if (rvalid_stall && !rvalid) begin
			report_other("rvalid dropped while rready was low");
		end
		bvalid_stall = bvalid && !bready;
		rvalid_stall = rvalid && !rready;

		if (awvalid && awready) begin
			if (!(wvalid && wready)) begin
				report_other("address and data handshakes did not complete together");
			end
			dirty = 1'b1;
			wr_model_resp = write_resp(awaddr);
			case (awaddr)
				8'h00: ctrl = wdata[1:0];
				8'h04: win_x = wdata[9:0];
				8'h08: win_y = wdata[9:0];
				8'h0C: bg_color = wdata[15:0];
				8'h10: vram_addr = wdata[10:0];
				8'h14: begin
					ram[vram_addr] = wdata[7:0];
					ram_known[vram_addr] = 1'b1;
					vram_addr = vram_addr + 1'b1;
				end
				default: ;
			endcase
		end
		if (bvalid && bready) begin
			compare("bresp", wr_model_resp, bresp);
			if (expected.size() == 0) begin
				report_other("write response with no transaction pending");
			end else begin
				e = expected.pop_front();
				compare("bresp", e[33:32], bresp);
			end
		end

		if (arvalid && arready) begin
			rd_model = read_model(araddr);
			rd_frame = (araddr == 8'h18);
		end
		if (rvalid && rready) begin
			compare("rresp", rd_model[33:32], rresp);
			if (rd_frame) begin
				// frames completed between reads equals vsync pulses seen between them
				compare("FRAME_CNT growth", vsync_rises - rises_at_read, rdata - frame_at_read);
				if (frame_growth >= 0) begin
					compare("FRAME_CNT frames", frame_growth, rdata - frame_at_read);
					frame_growth = -1;
				end
				rises_at_read = vsync_rises;
				frame_at_read = rdata;
			end else if (rd_model[33:32] == OKAY) begin
				compare("rdata", rd_model[31:0], rdata);
			end
			if (expected.size() == 0) begin
				report_other("read response with no transaction pending");
			end else begin
				e = expected.pop_front();
				compare("rresp", e[33:32], rresp);
				if (e[34]) begin
					compare("rdata", e[31:0], rdata);
				end
			end
		end
	endtask

	task automatic check_pixel(input int px, input int py);
		logic [15:0] v;
		int a;
		logic known;
		known = 1'b1;
		if (!ctrl[0]) begin
			v = 16'd0;
		end else if (px >= win_x && px < win_x + `WIN_W && py >= win_y &&
			py < win_y + `WIN_H) begin
			a = ((py - win_y) >> `TEXEL_SHIFT) * (`WIN_W >> `TEXEL_SHIFT) +
				((px - win_x) >> `TEXEL_SHIFT);
			known = ram_known[a];
			v = {ram[a], ram[a]};
		end else if (ctrl[1]) begin
			v = 16'(px + py);
		end else begin
			v = bg_color;
		end
		if (known) begin
			compare("lcd_r", v[15:11], lcd_r);
			compare("lcd_g", v[10:5], lcd_g);
			compare("lcd_b", v[4:0], lcd_b);
		end
	endtask

	task automatic pixel_step();
		if (vsync_prev && !lcd_vsync) begin
			pix_cnt = 0;
			synced = 1'b1;
			dirty = 1'b0;
		end
		if (!vsync_prev && lcd_vsync) begin
			vsync_rises++;
		end
		vsync_prev = lcd_vsync;
		if (!lcd_den) begin
			compare("blank colour", 32'd0, {lcd_r, lcd_g, lcd_b});
		end else begin
			// frames that saw a register or RAM write are only partly valid
			if (synced && !dirty) begin
				check_pixel(pix_cnt % `H_ACTIVE, pix_cnt / `H_ACTIVE);
			end
			pix_cnt++;
		end
	endtask

	// the panel clock follows the pixel clock in both phases
	always @(pixel_clk) begin
		#1;
		compare("lcd_clk", pixel_clk, lcd_clk);
	end

	always @(negedge pixel_clk) begin
		if (!rst) begin
			compare("lcd_hsync", 1, lcd_hsync);
			compare("lcd_vsync", 1, lcd_vsync);
			compare("lcd_den", 0, lcd_den);
			compare("awready", 0, awready);
			compare("wready", 0, wready);
			compare("arready", 0, arready);
			compare("bvalid", 0, bvalid);
			compare("rvalid", 0, rvalid);
			ctrl = 2'b01;
			win_x = '0;
			win_y = '0;
			bg_color = '0;
			vram_addr = '0;
			bvalid_stall = 1'b0;
			rvalid_stall = 1'b0;
			vsync_prev = 1'b1;
			dirty = 1'b0;
			synced = 1'b0;
			pix_cnt = 0;
			vsync_rises = 0;
			rises_at_read = 0;
			frame_at_read = '0;
			frame_growth = -1;
		end else begin
			pixel_step();
			bus_step();
		end
	end

endmodule

`default_nettype wire

/* source/lcd_top.sv */
`default_nettype none
`timescale 1ns/10ps
`include "lcd_cfg.svh"

module lcd_top (
	input wire logic pixel_clk,
	input wire logic rst,
	input wire logic [7:0] awaddr,
	input wire logic awvalid,
	output logic awready,
	input wire logic [31:0] wdata,
	input wire logic [3:0] wstrb,
	input wire logic wvalid,
	output logic wready,
	output regs_pkg::resp_t bresp,
	output logic bvalid,
	input wire logic bready,
	input wire logic [7:0] araddr,
	input wire logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output regs_pkg::resp_t rresp,
	output logic rvalid,
	input wire logic rready,
	output logic lcd_clk,
	output logic lcd_hsync,
	output logic lcd_vsync,
	output logic lcd_den,
	output logic [`R_MSB:0] lcd_r,
	output logic [`G_MSB:0] lcd_g,
	output logic [`B_MSB:0] lcd_b
);

	video_pkg::coord_t x;
	video_pkg::coord_t y;
	logic hsync;
	logic vsync;
	logic den;
	logic frame_end;
	logic disp_en;
	logic bg_pattern;
	video_pkg::coord_t win_x;
	video_pkg::coord_t win_y;
	video_pkg::rgb565_t bg_color;
	logic ram_we;
	logic [`VRAM_AW-1:0] ram_waddr;
	video_pkg::texel_t ram_wdata;
	logic [`VRAM_AW-1:0] ram_raddr;
	video_pkg::texel_t ram_rdata;

	// the panel samples on the same clock the pipeline runs on
	assign lcd_clk = pixel_clk;

	lcd_timing timing (
		.pixel_clk(pixel_clk),
		.rst(rst),
		.x(x),
		.y(y),
		.hsync(hsync),
		.vsync(vsync),
		.den(den),
		.frame_end(frame_end)
	);

	lcd_regs regs (
		.pixel_clk(pixel_clk),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.frame_end(frame_end),
		.disp_en(disp_en),
		.bg_pattern(bg_pattern),
		.win_x(win_x),
		.win_y(win_y),
		.bg_color(bg_color),
		.ram_we(ram_we),
		.ram_waddr(ram_waddr),
		.ram_wdata(ram_wdata)
	);

	video_ram vmem (
		.pixel_clk(pixel_clk),
		.we(ram_we),
		.waddr(ram_waddr),
		.wdata(ram_wdata),
		.raddr(ram_raddr),
		.rdata(ram_rdata)
	);

	window_compositor comp (
		.pixel_clk(pixel_clk),
		.rst(rst),
		.x(x),
		.y(y),
		.hsync(hsync),
		.vsync(vsync),
		.den(den),
		.disp_en(disp_en),
		.bg_pattern(bg_pattern),
		.win_x(win_x),
		.win_y(win_y),
		.bg_color(bg_color),
		.raddr(ram_raddr),
		.rdata(ram_rdata),
		.lcd_hsync(lcd_hsync),
		.lcd_vsync(lcd_vsync),
		.lcd_den(lcd_den),
		.lcd_r(lcd_r),
		.lcd_g(lcd_g),
		.lcd_b(lcd_b)
	);

endmodule

`default_nettype wire

/* source/window_compositor.sv */
`default_nettype none
`timescale 1ns/10ps
`include "lcd_cfg.svh"

module window_compositor (
	input wire logic pixel_clk,
	input wire logic rst,
	input wire video_pkg::coord_t x,
	input wire video_pkg::coord_t y,
	input wire logic hsync,
	input wire logic vsync,
	input wire logic den,
	input wire logic disp_en,
	input wire logic bg_pattern,
	input wire video_pkg::coord_t win_x,
	input wire video_pkg::coord_t win_y,
	input wire video_pkg::rgb565_t bg_color,
	output logic [`VRAM_AW-1:0] raddr,
	input wire video_pkg::texel_t rdata,
	output logic lcd_hsync,
	output logic lcd_vsync,
	output logic lcd_den,
	output logic [`R_MSB:0] lcd_r,
	output logic [`G_MSB:0] lcd_g,
	output logic [`B_MSB:0] lcd_b
);

	localparam int COL_BITS = $clog2(`WIN_W) - `TEXEL_SHIFT;
	localparam int ROW_BITS = `VRAM_AW - COL_BITS;

	video_pkg::coord_t col_off;
	video_pkg::coord_t row_off;
	logic [10:0] x_end;
	logic [10:0] y_end;
	logic in_win;
	video_pkg::rgb565_t bg;
	logic in_win_q;
	video_pkg::rgb565_t bg_q;
	logic hsync_q;
	logic vsync_q;
	logic den_q;
	video_pkg::rgb565_t color;
	logic show;

	// one bit wider so a window near the right edge does not wrap
	assign x_end = {1'b0, win_x} + 11'(`WIN_W);
	assign y_end = {1'b0, win_y} + 11'(`WIN_H);
	assign in_win = (x >= win_x) && ({1'b0, x} < x_end) && (y >= win_y) && ({1'b0, y} < y_end);

	assign col_off = x - win_x;
	assign row_off = y - win_y;
	assign raddr = {row_off[`TEXEL_SHIFT +: ROW_BITS], col_off[`TEXEL_SHIFT +: COL_BITS]};

	assign bg = bg_pattern ? video_pkg::rgb565_t'({6'd0, x} + {6'd0, y}) : bg_color;

	// stage 1 lines up with the registered RAM read
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			in_win_q <= 1'b0;
			hsync_q <= 1'b1;
			vsync_q <= 1'b1;
			den_q <= 1'b0;
		end else begin
			in_win_q <= in_win;
			hsync_q <= hsync;
			vsync_q <= vsync;
			den_q <= den;
		end
	end

	always_ff @(posedge pixel_clk) begin
		bg_q <= bg;
	end

	assign color = in_win_q ? video_pkg::rgb565_t'({rdata, rdata}) : bg_q;
	assign show = den_q && disp_en;

	// stage 2, the top bits of each field go to the panel
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			lcd_hsync <= 1'b1;
			lcd_vsync <= 1'b1;
			lcd_den <= 1'b0;
			lcd_r <= '0;
			lcd_g <= '0;
			lcd_b <= '0;
		end else begin
			lcd_hsync <= hsync_q;
			lcd_vsync <= vsync_q;
			lcd_den <= den_q;
			lcd_r <= show ? color.r[4 -: `R_MSB + 1] : '0;
			lcd_g <= show ? color.g[5 -: `G_MSB + 1] : '0;
			lcd_b <= show ? color.b[4 -: `B_MSB + 1] : '0;
		end
	end

	a_blank_black: assert property (@(posedge pixel_clk) disable iff (!rst)
		!lcd_den |-> (lcd_r == '0) && (lcd_g == '0) && (lcd_b == '0));

endmodule

`default_nettype wire

/* source/lcd_regs.sv */
`default_nettype none
`timescale 1ns/10ps
`include "lcd_cfg.svh"

module lcd_regs (
	input wire logic pixel_clk,
	input wire logic rst,
	input wire logic [7:0] awaddr,
	input wire logic awvalid,
	output logic awready,
	input wire logic [31:0] wdata,
	input wire logic [3:0] wstrb,
	input wire logic wvalid,
	output logic wready,
	output regs_pkg::resp_t bresp,
	output logic bvalid,
	input wire logic bready,
	input wire logic [7:0] araddr,
	input wire logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output regs_pkg::resp_t rresp,
	output logic rvalid,
	input wire logic rready,
	input wire logic frame_end,
	output logic disp_en,
	output logic bg_pattern,
	output video_pkg::coord_t win_x,
	output video_pkg::coord_t win_y,
	output video_pkg::rgb565_t bg_color,
	output logic ram_we,
	output logic [`VRAM_AW-1:0] ram_waddr,
	output video_pkg::texel_t ram_wdata
);

	logic [1:0] ctrl;
	logic [`VRAM_AW-1:0] vram_addr;
	logic [31:0] frame_cnt;
	logic wr_accept;
	logic busy;
	logic [31:0] rd_value;
	regs_pkg::resp_t rd_resp;
	regs_pkg::resp_t wr_resp;

	assign awready = wr_accept;
	assign wready = wr_accept;
	assign disp_en = ctrl[0];
	assign bg_pattern = ctrl[1];

	// no new address while a response is outstanding or a handshake is in flight
	assign busy = bvalid || rvalid || wr_accept || arready;

	always_comb begin
		case (awaddr)
			regs_pkg::CTRL, regs_pkg::WIN_X, regs_pkg::WIN_Y, regs_pkg::BG_COLOR,
			regs_pkg::VRAM_ADDR, regs_pkg::VRAM_DATA: wr_resp = regs_pkg::OKAY;
			default: wr_resp = regs_pkg::SLVERR;
		endcase
	end

	// VRAM_DATA has no read-back and returns zero
	always_comb begin
		rd_value = '0;
		rd_resp = regs_pkg::OKAY;
		case (araddr)
			regs_pkg::CTRL: rd_value = 32'(ctrl);
			regs_pkg::WIN_X: rd_value = 32'(win_x);
			regs_pkg::WIN_Y: rd_value = 32'(win_y);
			regs_pkg::BG_COLOR: rd_value = 32'(bg_color);
			regs_pkg::VRAM_ADDR: rd_value = 32'(vram_addr);
			regs_pkg::VRAM_DATA: rd_value = '0;
			regs_pkg::FRAME_CNT: rd_value = frame_cnt;
			default: rd_resp = regs_pkg::SLVERR;
		endcase
	end

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			wr_accept <= 1'b0;
			arready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= regs_pkg::OKAY;
			rvalid <= 1'b0;
			rresp <= regs_pkg::OKAY;
		end else begin
			wr_accept <= !busy && awvalid && wvalid;
			arready <= !busy && arvalid;
			if (wr_accept) begin
				bvalid <= 1'b1;
				bresp <= wr_resp;
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
			if (arready) begin
				rvalid <= 1'b1;
				rresp <= rd_resp;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge pixel_clk) begin
		if (arready) begin
			rdata <= rd_value;
		end
		if (wr_accept) begin
			ram_waddr <= vram_addr;
			ram_wdata <= wdata[7:0];
		end
	end

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			ctrl <= 2'b01;
			win_x <= '0;
			win_y <= '0;
			bg_color <= '0;
			vram_addr <= '0;
			frame_cnt <= '0;
			ram_we <= 1'b0;
		end else begin
			ram_we <= 1'b0;
			if (frame_end) begin
				frame_cnt <= frame_cnt + 1'b1;
			end
			if (wr_accept) begin
				case (awaddr)
					regs_pkg::CTRL: ctrl <= wdata[1:0];
					regs_pkg::WIN_X: win_x <= wdata[9:0];
					regs_pkg::WIN_Y: win_y <= wdata[9:0];
					regs_pkg::BG_COLOR: bg_color <= wdata[15:0];
					regs_pkg::VRAM_ADDR: vram_addr <= wdata[`VRAM_AW-1:0];
					regs_pkg::VRAM_DATA: begin
						// address wraps naturally at the RAM size
						ram_we <= 1'b1;
						vram_addr <= vram_addr + 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	a_bvalid_hold: assert property (@(posedge pixel_clk) disable iff (!rst)
		bvalid && !bready |=> bvalid);

	a_rvalid_hold: assert property (@(posedge pixel_clk) disable iff (!rst)
		rvalid && !rready |=> rvalid);

endmodule

`default_nettype wire

/* source/video_ram.sv */
`default_nettype none
`timescale 1ns/10ps
`include "lcd_cfg.svh"

module video_ram (
	input wire logic pixel_clk,
	input wire logic we,
	input wire logic [`VRAM_AW-1:0] waddr,
	input wire video_pkg::texel_t wdata,
	input wire logic [`VRAM_AW-1:0] raddr,
	output video_pkg::texel_t rdata
);

	localparam int DEPTH = 1 << `VRAM_AW;

	video_pkg::texel_t mem [0:DEPTH-1];

	// bus side write port
	always_ff @(posedge pixel_clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// read data is registered, which gives the compositor its first stage
	always_ff @(posedge pixel_clk) begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

/* source/lcd_timing.sv */
`default_nettype none
`timescale 1ns/10ps
`include "lcd_cfg.svh"

module lcd_timing (
	input wire logic pixel_clk,
	input wire logic rst,
	output video_pkg::coord_t x,
	output video_pkg::coord_t y,
	output logic hsync,
	output logic vsync,
	output logic den,
	output logic frame_end
);

	localparam int H_TOTAL = `H_ACTIVE + `H_FP + `H_SYNC + `H_BP;
	localparam int V_TOTAL = `V_ACTIVE + `V_FP + `V_SYNC + `V_BP;
	localparam int H_SYNC_START = `H_ACTIVE + `H_FP;
	localparam int H_SYNC_END = H_SYNC_START + `H_SYNC;
	localparam int V_SYNC_START = `V_ACTIVE + `V_FP;
	localparam int V_SYNC_END = V_SYNC_START + `V_SYNC;

	logic line_end;
	logic last_line;

	assign line_end = (x == video_pkg::coord_t'(H_TOTAL - 1));
	assign last_line = (y == video_pkg::coord_t'(V_TOTAL - 1));

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			x <= '0;
			y <= '0;
		end else if (line_end) begin
			x <= '0;
			y <= last_line ? '0 : y + 1'b1;
		end else begin
			x <= x + 1'b1;
		end
	end

	// everything below decodes the same registered counters
	assign den = (x < video_pkg::coord_t'(`H_ACTIVE)) && (y < video_pkg::coord_t'(`V_ACTIVE));
	assign hsync = !((x >= video_pkg::coord_t'(H_SYNC_START)) &&
		(x < video_pkg::coord_t'(H_SYNC_END)));
	assign vsync = !((y >= video_pkg::coord_t'(V_SYNC_START)) &&
		(y < video_pkg::coord_t'(V_SYNC_END)));
	assign frame_end = line_end && last_line;

	// the sync pulse must sit entirely in horizontal blanking
	a_den_outside_hsync: assert property (@(posedge pixel_clk) disable iff (!rst)
		!(den && !hsync));

endmodule

`default_nettype wire

/* source/regs_pkg.sv */
`default_nettype none

package regs_pkg;

	// byte offsets of the register block
	localparam logic [7:0] CTRL      = 8'h00;
	localparam logic [7:0] WIN_X     = 8'h04;
	localparam logic [7:0] WIN_Y     = 8'h08;
	localparam logic [7:0] BG_COLOR  = 8'h0C;
	localparam logic [7:0] VRAM_ADDR = 8'h10;
	localparam logic [7:0] VRAM_DATA = 8'h14;
	localparam logic [7:0] FRAME_CNT = 8'h18;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} resp_t;

endpackage

`default_nettype wire

/* source/video_pkg.sv */
`default_nettype none

package video_pkg;

	// screen coordinate, wide enough for the full line and frame totals
	typedef logic [9:0] coord_t;

	// packed 5-6-5 colour, red in the top bits
	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	// one grey level as stored in video RAM
	typedef logic [7:0] texel_t;

endpackage

`default_nettype wire

/* source/lcd_cfg.svh */
`ifndef LCD_CFG_SVH
`define LCD_CFG_SVH

// horizontal timing in pixel clocks, active area first
`define H_ACTIVE 480
`define H_FP 2
`define H_SYNC 41
`define H_BP 2

// vertical timing in lines
`define V_ACTIVE 272
`define V_FP 2
`define V_SYNC 10
`define V_BP 2

// picture window on the panel, in pixels
`define WIN_W 256
`define WIN_H 128

// one RAM byte covers a block of 4x4 pixels
`define TEXEL_SHIFT 2
`define VRAM_AW 11

`define R_MSB 4
`define G_MSB 5
`define B_MSB 4

`endif
